/* bp_mc_bridge.f */
hdl/bp_mc_pkg.sv
hdl/cmd_queue.sv
hdl/mc_addr_router.sv
hdl/trans_reorder_buf.sv
hdl/bp_mc_bridge.sv
test/mesh_responder.sv
test/bp_mc_bridge_tb.sv

/* test/bp_mc_bridge_tb.sv */
module bp_mc_bridge_tb;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int NUM_VEC     = 12;
  localparam int RESET_CYC   = 16;
  localparam int CYCLE_LIMIT = RESET_CYC + 40 * NUM_VEC;

  // stimulus, then the expected packet fields
  typedef struct packed
  {
    bp_mc_pkg::paddr_t    addr;
    bp_mc_pkg::msg_type_e msg_type;
    bp_mc_pkg::msg_size_e size;
    bp_mc_pkg::word_t     data;
    bp_mc_pkg::coord_t    x;
    bp_mc_pkg::coord_t    y;
    bp_mc_pkg::epa_t      epa;
    bp_mc_pkg::mc_op_e    op;
    bp_mc_pkg::mask_t     mask;
    bp_mc_pkg::word_t     payload;
  } vec_s;

  logic                  clk_i = 1'b0;
  logic                  rst_n_i;
  bp_mc_pkg::mem_msg_s   cmd_i;
  logic                  cmd_v_i;
  logic                  cmd_ready_o;
  bp_mc_pkg::mem_msg_s   resp_o;
  logic                  resp_v_o;
  logic                  resp_yumi_i;
  bp_mc_pkg::mc_packet_s pkt_o;
  logic                  pkt_v_o;
  logic                  pkt_ready_i;
  bp_mc_pkg::mc_return_s ret_i;
  logic                  ret_v_i;
  bp_mc_pkg::coord_t     my_x_i;
  bp_mc_pkg::coord_t     my_y_i;

  vec_s tbl [NUM_VEC];
  int   pkt_idx;
  int   resp_idx;
  int   cycles;
  int   checks;
  int   mismatches;
  int   other_errs;

  always #2 clk_i = ~clk_i;

  bp_mc_bridge UUT
    (
      .clk_i       (clk_i)
    , .rst_n_i     (rst_n_i)
    , .cmd_i       (cmd_i)
    , .cmd_v_i     (cmd_v_i)
    , .cmd_ready_o (cmd_ready_o)
    , .resp_o      (resp_o)
    , .resp_v_o    (resp_v_o)
    , .resp_yumi_i (resp_yumi_i)
    , .pkt_o       (pkt_o)
    , .pkt_v_o     (pkt_v_o)
    , .pkt_ready_i (pkt_ready_i)
    , .ret_i       (ret_i)
    , .ret_v_i     (ret_v_i)
    , .my_x_i      (my_x_i)
    , .my_y_i      (my_y_i)
    );

  mesh_responder mesh_responder_inst
    (
      .clk_i       (clk_i)
    , .rst_n_i     (rst_n_i)
    , .pkt_i       (pkt_o)
    , .pkt_v_i     (pkt_v_o)
    , .pkt_ready_o (pkt_ready_i)
    , .ret_o       (ret_i)
    , .ret_v_o     (ret_v_i)
    );

  //////////////////////////////
  // vector table
  //////////////////////////////
  // mesh direct 0 1 6 9, dram 2 3 7 10, host 4 5 8 11
  task automatic load_vectors();
    tbl[0]  = '{40'h88_7048_D158, bp_mc_pkg::e_msg_rd, bp_mc_pkg::e_size_4, 32'h0,
                6'd7, 6'd2, 26'h012_3456, bp_mc_pkg::e_remote_load, 4'h0, 32'h0};
    tbl[1]  = '{40'hFE_A02A_F37B, bp_mc_pkg::e_msg_wr, bp_mc_pkg::e_size_1, 32'h0000_00C3,
                6'd42, 6'd31, 26'h00A_BCDE, bp_mc_pkg::e_remote_store, 4'h8, 32'hC300_0000};
    tbl[2]  = '{40'h00_8123_45E6, bp_mc_pkg::e_msg_rd, bp_mc_pkg::e_size_2, 32'h0,
                6'd8, 6'd9, 26'h004_8D11, bp_mc_pkg::e_remote_load, 4'h0, 32'h0};
    tbl[3]  = '{40'h00_FFFF_0040, bp_mc_pkg::e_msg_wr, bp_mc_pkg::e_size_4, 32'hDEAD_BEEF,
                6'd3, 6'd0, 26'h1FF_FC00, bp_mc_pkg::e_remote_store, 4'hF, 32'hDEAD_BEEF};
    tbl[4]  = '{40'h00_1234_5679, bp_mc_pkg::e_msg_rd, bp_mc_pkg::e_size_1, 32'h0,
                6'd0, 6'd4, 26'h08D_159E, bp_mc_pkg::e_remote_load, 4'h0, 32'h0};
    tbl[5]  = '{40'h00_0000_100A, bp_mc_pkg::e_msg_wr, bp_mc_pkg::e_size_2, 32'h0000_BEEF,
                6'd0, 6'd4, 26'h000_0402, bp_mc_pkg::e_remote_store, 4'hC, 32'hBEEF_0000};
    tbl[6]  = '{40'h80_0FFF_FFFD, bp_mc_pkg::e_msg_wr, bp_mc_pkg::e_size_2, 32'h1234_5678,
                6'd0, 6'd0, 26'h3FF_FFFF, bp_mc_pkg::e_remote_store, 4'h6, 32'h3456_7800};
    tbl[7]  = '{40'h00_A5A5_A5A7, bp_mc_pkg::e_msg_rd, bp_mc_pkg::e_size_1, 32'h0,
                6'd6, 6'd9, 26'h096_9691, bp_mc_pkg::e_remote_load, 4'h0, 32'h0};
    tbl[8]  = '{40'h00_7FFF_FFFF, bp_mc_pkg::e_msg_wr, bp_mc_pkg::e_size_4, 32'hCAFE_F00D,
                6'd0, 6'd4, 26'h3FF_FFFF, bp_mc_pkg::e_remote_store, 4'h8, 32'h0D00_0000};
    tbl[9]  = '{40'hC2_0000_0007, bp_mc_pkg::e_msg_rd, bp_mc_pkg::e_size_2, 32'h0,
                6'd32, 6'd16, 26'h000_0001, bp_mc_pkg::e_remote_load, 4'h0, 32'h0};
    tbl[10] = '{40'h12_0000_0125, bp_mc_pkg::e_msg_wr, bp_mc_pkg::e_size_1, 32'h0000_005A,
                6'd2, 6'd9, 26'h000_0001, bp_mc_pkg::e_remote_store, 4'h2, 32'h0000_5A00};
    tbl[11] = '{40'h00_0ABC_DEF0, bp_mc_pkg::e_msg_rd, bp_mc_pkg::e_size_4, 32'h0,
                6'd0, 6'd4, 26'h2AF_37BC, bp_mc_pkg::e_remote_load, 4'h0, 32'h0};
  endtask

  //////////////////////////////
  // checking
  //////////////////////////////
  task automatic check_field(input string name, input logic [47:0] got,
                             input logic [47:0] exp);
    checks++;
    assert (got === exp)
    else
    begin
      mismatches++;
      $display("Mismatch at %0t: %s expected %0h, got %0h", $time, name, exp, got);
    end
  endtask

  task automatic check_packet(input int n);
    vec_s v;
    logic is_rd;
    v     = tbl[n];
    is_rd = (v.msg_type == bp_mc_pkg::e_msg_rd);
    check_field("pkt_o.x_dst", pkt_o.x_dst, v.x);
    check_field("pkt_o.y_dst", pkt_o.y_dst, v.y);
    check_field("pkt_o.x_src", pkt_o.x_src, my_x_i);
    check_field("pkt_o.y_src", pkt_o.y_src, my_y_i);
    check_field("pkt_o.epa", pkt_o.epa, v.epa);
    check_field("pkt_o.op", pkt_o.op, v.op);
    check_field("pkt_o.mask", pkt_o.mask, v.mask);
    check_field("pkt_o.payload", pkt_o.payload, v.payload);
    // ids are handed out in issue order and wrap
    check_field("pkt_o.trans_id", pkt_o.trans_id, n % bp_mc_pkg::MAX_OUTSTANDING);
    // load flags only for reads
    check_field("pkt_o.is_byte", pkt_o.is_byte, is_rd && v.size == bp_mc_pkg::e_size_1);
    check_field("pkt_o.is_hex", pkt_o.is_hex, is_rd && v.size == bp_mc_pkg::e_size_2);
    check_field("pkt_o.part_sel", pkt_o.part_sel, is_rd ? v.addr[1:0] : 2'b00);
  endtask

  task automatic check_response(input int n);
    vec_s             v;
    bp_mc_pkg::word_t exp_data;
    v = tbl[n];
    if (v.msg_type == bp_mc_pkg::e_msg_rd)
      exp_data = bp_mc_pkg::word_t'(v.epa) ^ 32'hA5A5_0000;
    else
      exp_data = '0;
    check_field("resp_o.header", resp_o.header, {v.msg_type, v.size, v.addr});
    check_field("resp_o.data", resp_o.data, exp_data);
  endtask

  task automatic print_summary();
    $display("checks %0d, mismatches %0d, other errors %0d", checks, mismatches, other_errs);
  endtask

  // transfers seen mid cycle take place at the next rising edge
  always @(negedge clk_i)
  begin
    if (rst_n_i && pkt_v_o && pkt_ready_i)
    begin
      assert (pkt_idx < NUM_VEC)
      else
      begin
        other_errs++;
        $display("Error at %0t: packet sent with no command left to match it", $time);
      end
      if (pkt_idx < NUM_VEC)
        check_packet(pkt_idx);
      pkt_idx++;
    end
    if (rst_n_i && resp_v_o && resp_yumi_i)
    begin
      assert (resp_idx < NUM_VEC)
      else
      begin
        other_errs++;
        $display("Error at %0t: response given with no command left to match it", $time);
      end
      if (resp_idx < NUM_VEC)
        check_response(resp_idx);
      resp_idx++;
    end
  end

  // consumer takes a valid response only some of the time
  always @(posedge clk_i)
  begin
    #1;
    resp_yumi_i = resp_v_o && ($urandom % 3 != 0);
  end

  always @(posedge clk_i)
  begin
    cycles++;
    if (cycles > CYCLE_LIMIT)
    begin
      other_errs++;
      $display("Error at %0t: run stalled, %0d of %0d responses after %0d cycles",
               $time, resp_idx, NUM_VEC, CYCLE_LIMIT);
      print_summary();
      $display("*** FAILED ***");
      $finish;
    end
  end

  //////////////////////////////
  // main sequence
  //////////////////////////////
  initial
  begin
    void'($urandom(22));
    rst_n_i     = 1'b0;
    cmd_i       = '0;
    cmd_v_i     = 1'b0;
    resp_yumi_i = 1'b0;
    my_x_i      = 6'd3;
    my_y_i      = 6'd5;
    pkt_idx     = 0;
    resp_idx    = 0;
    cycles      = 0;
    checks      = 0;
    mismatches  = 0;
    other_errs  = 0;
    load_vectors();
    repeat (RESET_CYC) @(posedge clk_i);
    #1;
    rst_n_i = 1'b1;
    checks++;
    assert (!pkt_v_o && !resp_v_o && cmd_ready_o)
    else
    begin
      other_errs++;
      $display("Error at %0t: bridge not idle after reset (pkt_v_o %b resp_v_o %b ready %b)",
               $time, pkt_v_o, resp_v_o, cmd_ready_o);
    end
    for (int i = 0; i < NUM_VEC; i++)
    begin
      @(posedge clk_i);
      #1;
      cmd_i.header.msg_type = tbl[i].msg_type;
      cmd_i.header.size     = tbl[i].size;
      cmd_i.header.addr     = tbl[i].addr;
      cmd_i.data            = tbl[i].data;
      cmd_v_i               = 1'b1;
      @(negedge clk_i);
      while (!cmd_ready_o)
        @(negedge clk_i);
    end
    @(posedge clk_i);
    #1;
    cmd_v_i = 1'b0;
    wait (resp_idx == NUM_VEC);
    // a few idle cycles to catch duplicates
    repeat (10) @(posedge clk_i);
    checks++;
    assert (pkt_idx == NUM_VEC && resp_idx == NUM_VEC)
    else
    begin
      other_errs++;
      $display("Error at %0t: expected %0d packets and responses, saw %0d and %0d",
               $time, NUM_VEC, pkt_idx, resp_idx);
    end
    print_summary();
    if (mismatches == 0 && other_errs == 0)
      $display("*** PASSED ***");
    else
      $display("*** FAILED ***");
    $finish;
  end

endmodule

/* test/mesh_responder.sv */
module mesh_responder
  (
    input  logic                  clk_i
  , input  logic                  rst_n_i

  , input  bp_mc_pkg::mc_packet_s pkt_i
  , input  logic                  pkt_v_i
  , output logic                  pkt_ready_o

  , output bp_mc_pkg::mc_return_s ret_o
  , output logic                  ret_v_o
  );
  timeunit 1ns;
  timeprecision 1ps;

  localparam int SLOTS = 4;

  logic [SLOTS-1:0]      held;
  bp_mc_pkg::mc_return_s slot_ret [SLOTS];
  int unsigned           slot_wait [SLOTS];
  logic                  take;
  bp_mc_pkg::mc_return_s take_ret;
  logic                  placed;
  int                    start;
  int                    idx;

  initial
  begin
    pkt_ready_o = 1'b0;
    ret_o       = '0;
    ret_v_o     = 1'b0;
    held        = '0;
    take        = 1'b0;
  end

  // handshake is settled by mid cycle
  always @(negedge clk_i)
  begin
    take              = rst_n_i && pkt_v_i && pkt_ready_o;
    take_ret.trans_id = pkt_i.trans_id;
    take_ret.data     = bp_mc_pkg::word_t'(pkt_i.epa) ^ 32'hA5A5_0000;
  end

  always @(posedge clk_i)
  begin
    #1;
    ret_v_o = 1'b0;
    placed  = 1'b0;
    // store the new packet, age the others
    for (int i = 0; i < SLOTS; i++)
    begin
      if (take && !placed && !held[i])
      begin
        held[i]      = 1'b1;
        slot_ret[i]  = take_ret;
        slot_wait[i] = $urandom_range(12, 1);
        placed       = 1'b1;
      end
      else if (held[i] && slot_wait[i] != 0)
        slot_wait[i]--;
    end
    // at most one return per cycle, random pick among the ripe slots
    start = $urandom % SLOTS;
    for (int k = 0; k < SLOTS; k++)
    begin
      idx = (start + k) % SLOTS;
      if (!ret_v_o && held[idx] && slot_wait[idx] == 0)
      begin
        ret_o     = slot_ret[idx];
        ret_v_o   = 1'b1;
        held[idx] = 1'b0;
      end
    end
    pkt_ready_o = rst_n_i && (held != '1) && ($urandom % 4 != 0);
  end

endmodule

/* hdl/bp_mc_bridge.sv */
module bp_mc_bridge
  (
    input  logic                  clk_i
  , input  logic                  rst_n_i

    // processor commands
  , input  bp_mc_pkg::mem_msg_s   cmd_i
  , input  logic                  cmd_v_i
  , output logic                  cmd_ready_o

    // processor responses
  , output bp_mc_pkg::mem_msg_s   resp_o
  , output logic                  resp_v_o
  , input  logic                  resp_yumi_i

    // mesh requests
  , output bp_mc_pkg::mc_packet_s pkt_o
  , output logic                  pkt_v_o
  , input  logic                  pkt_ready_i

    // mesh returns
  , input  bp_mc_pkg::mc_return_s ret_i
  , input  logic                  ret_v_i

  , input  bp_mc_pkg::coord_t     my_x_i
  , input  bp_mc_pkg::coord_t     my_y_i
  );

  bp_mc_pkg::mem_msg_s  q_cmd;
  logic                 q_v;
  bp_mc_pkg::trans_id_t alloc_id;
  logic                 alloc_v;
  logic                 issue;

  //////////////////////////////
  // command queue
  //////////////////////////////
  cmd_queue cmd_queue_inst
    (
      .clk_i   (clk_i)
    , .rst_n_i (rst_n_i)
    , .data_i  (cmd_i)
    , .v_i     (cmd_v_i)
    , .ready_o (cmd_ready_o)
    , .data_o  (q_cmd)
    , .v_o     (q_v)
    , .yumi_i  (issue)
    );

  //////////////////////////////
  // issue
  //////////////////////////////
  // one condition pops the queue, takes the id and sends the packet
  assign issue   = q_v & alloc_v & pkt_ready_i;
  assign pkt_v_o = issue;

  mc_addr_router mc_addr_router_inst
    (
      .cmd_i      (q_cmd)
    , .trans_id_i (alloc_id)
    , .my_x_i     (my_x_i)
    , .my_y_i     (my_y_i)
    , .pkt_o      (pkt_o)
    );

  //////////////////////////////
  // return and reorder
  //////////////////////////////
  trans_reorder_buf trans_reorder_buf_inst
    (
      .clk_i        (clk_i)
    , .rst_n_i      (rst_n_i)
    , .alloc_id_o   (alloc_id)
    , .alloc_v_o    (alloc_v)
    , .alloc_yumi_i (issue)
    , .hdr_i        (q_cmd.header)
    , .ret_i        (ret_i)
    , .ret_v_i      (ret_v_i)
    , .resp_o       (resp_o)
    , .resp_v_o     (resp_v_o)
    , .deq_yumi_i   (resp_yumi_i)
    );

endmodule

/* hdl/trans_reorder_buf.sv */
module trans_reorder_buf
  (
    input  logic                   clk_i
  , input  logic                   rst_n_i

    // id allocation at issue
  , output bp_mc_pkg::trans_id_t   alloc_id_o
  , output logic                   alloc_v_o
  , input  logic                   alloc_yumi_i
  , input  bp_mc_pkg::mem_header_s hdr_i

    // returns from the mesh, any order
  , input  bp_mc_pkg::mc_return_s  ret_i
  , input  logic                   ret_v_i

    // responses in issue order
  , output bp_mc_pkg::mem_msg_s    resp_o
  , output logic                   resp_v_o
  , input  logic                   deq_yumi_i
  );

  typedef logic [bp_mc_pkg::TRANS_ID_W:0] count_t;

  bp_mc_pkg::mem_header_s hdr_mem [bp_mc_pkg::MAX_OUTSTANDING];
  bp_mc_pkg::word_t       data_mem [bp_mc_pkg::MAX_OUTSTANDING];

  logic [bp_mc_pkg::MAX_OUTSTANDING-1:0] done_q;
  bp_mc_pkg::trans_id_t                  alloc_ptr_q;
  bp_mc_pkg::trans_id_t                  deq_ptr_q;
  count_t                                count_q;
  logic                                  alloc;
  logic                                  deq;
  bp_mc_pkg::mem_header_s                deq_hdr;

  assign alloc_v_o  = (count_q != count_t'(bp_mc_pkg::MAX_OUTSTANDING));
  assign alloc_id_o = alloc_ptr_q;
  assign alloc      = alloc_yumi_i & alloc_v_o;

  // oldest slot drives the response once its return is in
  assign resp_v_o = done_q[deq_ptr_q];
  assign deq      = deq_yumi_i & resp_v_o;
  assign deq_hdr  = hdr_mem[deq_ptr_q];

  always_comb
  begin
    resp_o.header = deq_hdr;
    if (deq_hdr.msg_type == bp_mc_pkg::e_msg_wr)
      resp_o.data = '0;
    else
      resp_o.data = data_mem[deq_ptr_q];
  end

  //////////////////////////////
  // slot tracking
  //////////////////////////////
  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      alloc_ptr_q <= '0;
      deq_ptr_q   <= '0;
      count_q     <= '0;
      done_q      <= '0;
    end
    else
    begin
      // ids wrap naturally, pool size is a power of two
      if (alloc)
        alloc_ptr_q <= alloc_ptr_q + 1'b1;
      if (deq)
        deq_ptr_q <= deq_ptr_q + 1'b1;
      case ({alloc, deq})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
      // a return never targets the slot being released
      if (ret_v_i)
        done_q[ret_i.trans_id] <= 1'b1;
      if (deq)
        done_q[deq_ptr_q] <= 1'b0;
    end
  end

  // header and data tables
  always_ff @(posedge clk_i)
  begin
    if (alloc)
      hdr_mem[alloc_ptr_q] <= hdr_i;
    if (ret_v_i)
      data_mem[ret_i.trans_id] <= ret_i.data;
  end

endmodule

/* hdl/mc_addr_router.sv */
module mc_addr_router
  (
    input  bp_mc_pkg::mem_msg_s   cmd_i
  , input  bp_mc_pkg::trans_id_t  trans_id_i
  , input  bp_mc_pkg::coord_t     my_x_i
  , input  bp_mc_pkg::coord_t     my_y_i
  , output bp_mc_pkg::mc_packet_s pkt_o
  );

  bp_mc_pkg::paddr_t addr;
  logic [1:0]        low_bits;
  logic              mesh_direct;
  logic              dram_hit;
  bp_mc_pkg::coord_t dst_x;
  bp_mc_pkg::coord_t dst_y;
  bp_mc_pkg::epa_t   dst_epa;
  bp_mc_pkg::mask_t  store_mask;

  assign addr        = cmd_i.header.addr;
  assign low_bits    = addr[1:0];
  assign mesh_direct = addr[bp_mc_pkg::PADDR_W-1];
  assign dram_hit    = !mesh_direct && (addr >= bp_mc_pkg::DRAM_BASE);

  //////////////////////////////
  // destination select
  //////////////////////////////
  always_comb
  begin
    if (mesh_direct)
    begin
      dst_x   = addr[33:28];
      dst_y   = bp_mc_pkg::coord_t'(addr[38:34]);
      dst_epa = addr[27:2];
    end
    else if (dram_hit)
    begin
      // stripe across the vcache columns, bit 8 picks north or south row
      dst_x   = bp_mc_pkg::DRAM_X_BASE + bp_mc_pkg::coord_t'(addr[7:5]);
      dst_y   = addr[8] ? bp_mc_pkg::DRAM_Y_SOUTH : bp_mc_pkg::DRAM_Y_NORTH;
      dst_epa = bp_mc_pkg::epa_t'({addr[30:9], addr[4:2]});
    end
    else
    begin
      // host sits one row above this link
      dst_x   = '0;
      dst_y   = my_y_i - 1'b1;
      dst_epa = addr[27:2];
    end
  end

  // byte lanes touched by a store
  always_comb
  begin
    case (cmd_i.header.size)
      bp_mc_pkg::e_size_1: store_mask = bp_mc_pkg::mask_t'(4'h1 << low_bits);
      bp_mc_pkg::e_size_2: store_mask = bp_mc_pkg::mask_t'(4'h3 << low_bits);
      default:             store_mask = bp_mc_pkg::mask_t'(4'hf << low_bits);
    endcase
  end

  //////////////////////////////
  // packet assembly
  //////////////////////////////
  always_comb
  begin
    pkt_o          = '0;
    pkt_o.x_dst    = dst_x;
    pkt_o.y_dst    = dst_y;
    pkt_o.x_src    = my_x_i;
    pkt_o.y_src    = my_y_i;
    pkt_o.epa      = dst_epa;
    pkt_o.trans_id = trans_id_i;
    if (cmd_i.header.msg_type == bp_mc_pkg::e_msg_wr)
    begin
      pkt_o.op      = bp_mc_pkg::e_remote_store;
      pkt_o.mask    = store_mask;
      pkt_o.payload = bp_mc_pkg::word_t'(cmd_i.data << {low_bits, 3'b000});
    end
    else
    begin
      pkt_o.op       = bp_mc_pkg::e_remote_load;
      pkt_o.is_byte  = (cmd_i.header.size == bp_mc_pkg::e_size_1);
      pkt_o.is_hex   = (cmd_i.header.size == bp_mc_pkg::e_size_2);
      pkt_o.part_sel = low_bits;
    end
  end

endmodule

/* hdl/cmd_queue.sv */
module cmd_queue
  (
    input  logic                clk_i
  , input  logic                rst_n_i

  , input  bp_mc_pkg::mem_msg_s data_i
  , input  logic                v_i
  , output logic                ready_o

  , output bp_mc_pkg::mem_msg_s data_o
  , output logic                v_o
  , input  logic                yumi_i
  );

  typedef logic [$clog2(bp_mc_pkg::CMD_FIFO_DEPTH)-1:0]   ptr_t;
  typedef logic [$clog2(bp_mc_pkg::CMD_FIFO_DEPTH+1)-1:0] count_t;

  bp_mc_pkg::mem_msg_s mem_q [bp_mc_pkg::CMD_FIFO_DEPTH];
  ptr_t   wr_ptr_q;
  ptr_t   rd_ptr_q;
  count_t count_q;
  logic   push;
  logic   pop;

  assign ready_o = (count_q != count_t'(bp_mc_pkg::CMD_FIFO_DEPTH));
  assign v_o     = (count_q != '0);
  assign push    = v_i & ready_o;
  assign pop     = yumi_i & v_o;
  assign data_o  = mem_q[rd_ptr_q];

  // pointers and occupancy
  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end
    else
    begin
      if (push)
        wr_ptr_q <= (wr_ptr_q == ptr_t'(bp_mc_pkg::CMD_FIFO_DEPTH-1)) ? '0 : wr_ptr_q + 1'b1;
      if (pop)
        rd_ptr_q <= (rd_ptr_q == ptr_t'(bp_mc_pkg::CMD_FIFO_DEPTH-1)) ? '0 : rd_ptr_q + 1'b1;
      case ({push, pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  // storage
  always_ff @(posedge clk_i)
  begin
    if (push)
      mem_q[wr_ptr_q] <= data_i;
  end

endmodule

/* hdl/bp_mc_pkg.sv */
package bp_mc_pkg;

  //////////////////////////////
  // widths and sizes
  //////////////////////////////
  localparam int PADDR_W         = 40;
  localparam int WORD_W          = 32;
  localparam int MASK_W          = WORD_W / 8;
  localparam int COORD_W         = 6;
  localparam int EPA_W           = 26;
  localparam int MAX_OUTSTANDING = 4;
  localparam int TRANS_ID_W      = 2;
  localparam int CMD_FIFO_DEPTH  = 2;

  typedef logic [PADDR_W-1:0]    paddr_t;
  typedef logic [WORD_W-1:0]     word_t;
  typedef logic [MASK_W-1:0]     mask_t;
  typedef logic [COORD_W-1:0]    coord_t;
  typedef logic [EPA_W-1:0]      epa_t;
  typedef logic [TRANS_ID_W-1:0] trans_id_t;

  //////////////////////////////
  // address map
  //////////////////////////////
  localparam paddr_t DRAM_BASE    = 40'h00_8000_0000;
  // vcache columns start here
  localparam coord_t DRAM_X_BASE  = 6'd1;
  localparam coord_t DRAM_Y_NORTH = 6'd0;
  localparam coord_t DRAM_Y_SOUTH = 6'd9;

  //////////////////////////////
  // processor side messages
  //////////////////////////////
  typedef enum logic [1:0]
  {
    e_msg_rd = 2'b00,
    e_msg_wr = 2'b01
  } msg_type_e;

  // log2 of the byte count
  typedef enum logic [1:0]
  {
    e_size_1 = 2'b00,
    e_size_2 = 2'b01,
    e_size_4 = 2'b10
  } msg_size_e;

  typedef struct packed
  {
    msg_type_e msg_type;
    msg_size_e size;
    paddr_t    addr;
  } mem_header_s;

  typedef struct packed
  {
    mem_header_s header;
    word_t       data;
  } mem_msg_s;

  //////////////////////////////
  // mesh side packets
  //////////////////////////////
  typedef enum logic
  {
    e_remote_load  = 1'b0,
    e_remote_store = 1'b1
  } mc_op_e;

  typedef struct packed
  {
    coord_t    x_dst;
    coord_t    y_dst;
    coord_t    x_src;
    coord_t    y_src;
    epa_t      epa;
    mc_op_e    op;
    trans_id_t trans_id;
    mask_t     mask;
    // load info, zero for stores
    logic       is_byte;
    logic       is_hex;
    logic [1:0] part_sel;
    word_t      payload;
  } mc_packet_s;

  typedef struct packed
  {
    trans_id_t trans_id;
    word_t     data;
  } mc_return_s;

endpackage
